//--- common/sram_pkg.sv
// --------------------
// sram package
// widths of the physical macro row and the fold limits shared by the
// SRAM wrapper, its fold fields and the macro model
// --------------------
package sram_pkg;

  // The technology offers a single macro shape, a 64-bit row with a
  // per-bit write mask. Logical words narrower than a row are folded.
  // Each field bit is copied once per slot, and the low address bits
  // pick the slot that a write enables or a read returns.
  //
  // Copies of one bit sit next to each other in the row
  // (bit * fold + slot), so the read mux stays local to a few columns.

  // data width of one physical macro row
  localparam int unsigned MacroWidth = 32'd64;

  // data bits covered by one byte enable
  localparam int unsigned ByteWidth = 32'd8;

  // most copies of a field bit in one row
  // a 7-bit field reaches it with 56 of 64 columns used
  localparam int unsigned MaxFold = 32'd8;

  localparam int unsigned FoldSelWidth = $clog2(MaxFold); // slot index bits

  // macro data in, data out and bit mask
  typedef logic [MacroWidth-1:0] macro_row_t;

  // slot index within a macro row
  typedef logic [FoldSelWidth-1:0] fold_sel_t;

endpackage

//--- rtl/sram_fold_field.sv
// --------------------
// sram_fold_field
// maps one field of the logical word onto a single 64-bit macro
// narrow fields are folded into several slots per row, the slot of a
// read is registered so the right copy is picked when data returns
// --------------------
`timescale 1ns/1ps

module sram_fold_field #(
  parameter int unsigned  NumWords   = 32'd512,
  parameter int unsigned  FieldWidth = 32'd32,
  localparam int unsigned AddrWidth  = (NumWords > 32'd1) ? $clog2(NumWords) : 32'd1
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  req_i,
  input  logic                  we_i,
  input  logic [AddrWidth-1:0]  addr_i,   // logical word address
  input  logic [FieldWidth-1:0] wdata_i,
  input  logic [FieldWidth-1:0] mask_i,   // bit mask of this field
  output logic [FieldWidth-1:0] rdata_o
);

  import sram_pkg::*;

  // largest power of two up to MaxFold that still fits in a row
  function automatic int unsigned calc_fold(int unsigned width);
    int unsigned fold;
    fold = 1;
    while ((fold * 2 <= MaxFold) && (fold * 2 * width <= MacroWidth)) begin
      fold = fold * 2;
    end
    return fold;
  endfunction

  localparam int unsigned Fold     = calc_fold(FieldWidth);
  localparam int unsigned SelWidth = $clog2(Fold);        // address bits naming the slot
  localparam int unsigned Rows     = NumWords / Fold;
  localparam int unsigned RowWidth = (Rows > 32'd1) ? $clog2(Rows) : 32'd1;

  logic [RowWidth-1:0] row_addr;
  macro_row_t          wdata_row;  // replicated field data
  macro_row_t          mask_row;
  macro_row_t          rdata_row;

  if (Fold == 1) begin : gen_direct
    // one word per row, field sits in the low columns
    assign row_addr = addr_i;

    always_comb begin
      wdata_row = '0;
      mask_row  = '0;
      wdata_row[FieldWidth-1:0] = wdata_i;
      mask_row[FieldWidth-1:0]  = mask_i;
    end

    assign rdata_o = rdata_row[FieldWidth-1:0];

  end else begin : gen_folded
    fold_sel_t slot_d;
    fold_sel_t slot_q;

    assign row_addr = addr_i[AddrWidth-1:SelWidth];
    assign slot_d   = fold_sel_t'(addr_i[SelWidth-1:0]);

    // copy k of bit b lives at column b*Fold+k
    // unused top columns stay zero and are never written
    always_comb begin
      wdata_row = '0;
      mask_row  = '0;
      for (int unsigned b = 0; b < FieldWidth; b++) begin
        for (int unsigned k = 0; k < Fold; k++) begin
          wdata_row[b*Fold+k] = wdata_i[b];
          mask_row[b*Fold+k]  = mask_i[b] & (slot_d == fold_sel_t'(k));
        end
      end
    end

    // loads on reads only, in step with the macro output register
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        slot_q <= '0;
      end else if (req_i && !we_i) begin
        slot_q <= slot_d;
      end
    end

    always_comb begin
      for (int unsigned b = 0; b < FieldWidth; b++) begin
        rdata_o[b] = rdata_row[b*Fold+slot_q];  // pick the slot of the last read
      end
    end
  end

  sram_macro_64 #(
    .Rows    ( Rows      )
  ) i_macro (
    .clk_i   ( clk_i     ),
    .rst_ni  ( rst_ni    ),
    .req_i   ( req_i     ),
    .we_i    ( we_i      ),
    .row_i   ( row_addr  ),
    .wdata_i ( wdata_row ),
    .mask_i  ( mask_row  ),
    .rdata_o ( rdata_row )
  );

endmodule

//--- rtl/sram_tc.sv
// --------------------
// sram_tc
// single-port SRAM with byte enables built from 64-bit macros
// expands byte enables to a bit mask and splits the word into fields
// one cycle read latency, supported widths 32, 39 and 64
// --------------------
`timescale 1ns/1ps

module sram_tc #(
  parameter int unsigned  NumWords  = 32'd512,
  parameter int unsigned  DataWidth = 32'd39,
  localparam int unsigned AddrWidth = (NumWords > 32'd1) ? $clog2(NumWords) : 32'd1,
  localparam int unsigned BeWidth   =
    (DataWidth + sram_pkg::ByteWidth - 32'd1) / sram_pkg::ByteWidth,
  localparam type         addr_t    = logic [AddrWidth-1:0],
  localparam type         data_t    = logic [DataWidth-1:0],
  localparam type         be_t      = logic [BeWidth-1:0]
) (
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  req_i,    // one-cycle request pulse
  input  logic  we_i,     // 1 write, 0 read
  input  addr_t addr_i,
  input  data_t wdata_i,
  input  be_t   be_i,     // byte enables, writes only
  output data_t rdata_o   // valid the cycle after a read, then held
);

  import sram_pkg::*;

  data_t bit_mask;

  // every data bit follows the enable of its byte
  // bits 32..38 of a 39-bit word share the fifth enable
  for (genvar b = 0; b < DataWidth; b++) begin : gen_bit_mask
    assign bit_mask[b] = be_i[b / ByteWidth];
  end

  if (DataWidth == 32 || DataWidth == 64) begin : gen_one_field
    // 64 maps straight onto the macro, 32 folds twice
    sram_fold_field #(
      .NumWords   ( NumWords  ),
      .FieldWidth ( DataWidth )
    ) i_field (
      .clk_i   ( clk_i    ),
      .rst_ni  ( rst_ni   ),
      .req_i   ( req_i    ),
      .we_i    ( we_i     ),
      .addr_i  ( addr_i   ),
      .wdata_i ( wdata_i  ),
      .mask_i  ( bit_mask ),
      .rdata_o ( rdata_o  )
    );

  end else if (DataWidth == 39) begin : gen_two_fields
    localparam int unsigned LoWidth = 32'd32;               // folds twice
    localparam int unsigned HiWidth = DataWidth - LoWidth;  // 7 bits, folds eight times

    sram_fold_field #(
      .NumWords   ( NumWords ),
      .FieldWidth ( LoWidth  )
    ) i_field_lo (
      .clk_i   ( clk_i                  ),
      .rst_ni  ( rst_ni                 ),
      .req_i   ( req_i                  ),
      .we_i    ( we_i                   ),
      .addr_i  ( addr_i                 ),
      .wdata_i ( wdata_i[LoWidth-1:0]   ),
      .mask_i  ( bit_mask[LoWidth-1:0]  ),
      .rdata_o ( rdata_o[LoWidth-1:0]   )
    );

    // the upper field uses a smaller macro with eight slots per row
    sram_fold_field #(
      .NumWords   ( NumWords ),
      .FieldWidth ( HiWidth  )
    ) i_field_hi (
      .clk_i   ( clk_i                         ),
      .rst_ni  ( rst_ni                        ),
      .req_i   ( req_i                         ),
      .we_i    ( we_i                          ),
      .addr_i  ( addr_i                        ),
      .wdata_i ( wdata_i[DataWidth-1:LoWidth]  ),
      .mask_i  ( bit_mask[DataWidth-1:LoWidth] ),
      .rdata_o ( rdata_o[DataWidth-1:LoWidth]  )
    );
  end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the SRAM wrapper testbench with Verilator
# once for a 39-bit word and once for a 64-bit word
set -e

cd "$(dirname "$0")"

pass_msg="Simulation finished: PASS"
status=0

for width in 39 64; do
  build_dir="obj_dir_w${width}"
  verilator --binary --timing \
    -f verilog.f \
    --top-module tb_sram_tc \
    -GDataWidth=${width} \
    --Mdir "${build_dir}" \
    -o sim_tb
  sim_out=$("./${build_dir}/sim_tb")
  echo "${sim_out}"
  if ! grep -qF "${pass_msg}" <<< "${sim_out}"; then
    echo "run with DataWidth ${width} did not pass"
    status=1
  fi
done

exit ${status}

//--- sram_macro/sram_macro_64.sv
// --------------------
// sram_macro_64
// behavioral model of the 64-bit single-port SRAM macro
// write under a per-bit mask, read data registered after one cycle
// --------------------
`timescale 1ns/1ps

module sram_macro_64 #(
  parameter int unsigned  Rows     = 32'd256,
  localparam int unsigned RowWidth = (Rows > 32'd1) ? $clog2(Rows) : 32'd1
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 req_i,   // macro enable
  input  logic                 we_i,    // 1 write, 0 read
  input  logic [RowWidth-1:0]  row_i,
  input  sram_pkg::macro_row_t wdata_i,
  input  sram_pkg::macro_row_t mask_i,  // bit-write mask
  output sram_pkg::macro_row_t rdata_o
);

  import sram_pkg::*;

  macro_row_t mem_q [Rows];
  macro_row_t rdata_q;
  logic       wr_en;
  logic       rd_en;

  assign wr_en = req_i & we_i;
  assign rd_en = req_i & ~we_i;

  // only masked bits take the new value
  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      mem_q[row_i] <= (mem_q[row_i] & ~mask_i) | (wdata_i & mask_i);
    end
  end

  // output register holds its row until the next read
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_q <= '0;
    end else if (rd_en) begin
      rdata_q <= mem_q[row_i];
    end
  end

  assign rdata_o = rdata_q;

endmodule

//--- verif/tb_clk_gen.sv
// --------------------
// tb_clk_gen
// testbench clock and active-low reset
// --------------------
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int unsigned HalfPeriod  = 32'd5,  // ns, 10 ns clock
  parameter int unsigned ResetCycles = 32'd8
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(HalfPeriod) clk_o = ~clk_o;
  end

  // reset released on a rising edge after ResetCycles edges
  initial begin
    rst_no <= 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    rst_no <= 1'b1;
  end

endmodule

//--- verif/tb_sram_model.svh
// --------------------
// reference memory model
// logical word array, byte enable expansion and masked merge
// --------------------
`ifndef TB_SRAM_MODEL_SVH
`define TB_SRAM_MODEL_SVH

data_t model_mem [NumWords];  // expected contents, one entry per word

// each data bit follows the enable of the byte it sits in
// the top partial byte of a 39-bit word uses the last enable
function automatic data_t expand_be(input be_t be_in);
  data_t m;
  for (int unsigned b = 0; b < DataWidth; b++) begin
    m[b] = be_in[b / ByteWidth];
  end
  return m;
endfunction

// new bits where the mask is set, old bits elsewhere
function automatic data_t merge_masked(input data_t old_val, input data_t new_val,
                                       input data_t mask);
  return (old_val & ~mask) | (new_val & mask);
endfunction

task automatic model_write(input addr_t a, input data_t d, input be_t be_in);
  model_mem[a] = merge_masked(model_mem[a], d, expand_be(be_in));
endtask

function automatic data_t model_read(input addr_t a);
  return model_mem[a];
endfunction

`endif

//--- verif/tb_sram_tc.sv
// --------------------
// tb_sram_tc
// directed tests of the SRAM wrapper against a reference model
// random data from a 16-bit Fibonacci LFSR
// --------------------
`timescale 1ns/1ps

module tb_sram_tc #(
  parameter int unsigned DataWidth = 32'd39,
  parameter int unsigned NumWords  = 32'd512
);

  import sram_pkg::*;

  localparam int unsigned AddrWidth   = (NumWords > 32'd1) ? $clog2(NumWords) : 32'd1;
  localparam int unsigned BeWidth     = (DataWidth + ByteWidth - 32'd1) / ByteWidth;
  localparam int unsigned ResetCycles = 32'd8;
  localparam int unsigned NumByteOps  = 32'd64;  // partial writes in byte_enables
  // operations of all tests, about 4 cycles each, twice for margin
  localparam int unsigned TestOps       = 32'd2 + 32'd2 * NumWords + 32'd2 * NumByteOps + 32'd28;
  localparam int unsigned TimeoutCycles = 32'd8 * TestOps + ResetCycles;

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;
  typedef logic [BeWidth-1:0]   be_t;

  logic  clk;
  logic  rst_n;
  logic  req;
  logic  we;
  addr_t addr;
  data_t wdata;
  be_t   be;
  data_t rdata;

  int unsigned errors    = 0;
  int unsigned checks    = 0;
  int unsigned cycle_cnt = 0;
  logic [15:0] lfsr_state = 16'd41315;

  `include "tb_sram_model.svh"

  tb_clk_gen #(
    .ResetCycles ( ResetCycles )
  ) i_clk_gen (
    .clk_o  ( clk   ),
    .rst_no ( rst_n )
  );

  sram_tc #(
    .NumWords  ( NumWords  ),
    .DataWidth ( DataWidth )
  ) DUT (
    .clk_i   ( clk   ),
    .rst_ni  ( rst_n ),
    .req_i   ( req   ),
    .we_i    ( we    ),
    .addr_i  ( addr  ),
    .wdata_i ( wdata ),
    .be_i    ( be    ),
    .rdata_o ( rdata )
  );

  // taps 16, 14, 13, 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
  endfunction

  function automatic logic [63:0] rand_bits(input int unsigned n);
    logic [63:0] r;
    r = '0;
    for (int unsigned i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);  // one step per bit
      r = {r[62:0], lfsr_state[0]};
    end
    return r;
  endfunction

  task automatic check_data(input string name, input data_t exp, input data_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Mismatch in %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic report_test(input string name, input int unsigned err_start);
    $display("%-20s %s, %0d errors", name, (errors == err_start) ? "passed" : "failed",
             errors - err_start);
  endtask

  task automatic drive_idle();
    @(posedge clk);
    req <= 1'b0;
    we  <= 1'b0;
  endtask

  task automatic issue_write(input addr_t a, input data_t d, input be_t b);
    @(posedge clk);
    req   <= 1'b1;
    we    <= 1'b1;
    addr  <= a;
    wdata <= d;
    be    <= b;
    model_write(a, d, b);
  endtask

  task automatic issue_read(input addr_t a);
    @(posedge clk);
    req  <= 1'b1;
    we   <= 1'b0;
    addr <= a;
  endtask

  // data is sampled on the falling edge after the capturing edge
  task automatic read_check(input string name, input addr_t a);
    issue_read(a);
    drive_idle();
    @(negedge clk);
    check_data(name, model_read(a), rdata);
  endtask

  task automatic test_reset_state();
    int unsigned e0;
    e0 = errors;
    drive_idle();
    drive_idle();
    @(negedge clk);
    check_data("reset_state", '0, rdata);
    report_test("reset_state", e0);
  endtask

  task automatic test_full_write_read();
    int unsigned e0;
    e0 = errors;
    for (int unsigned a = 0; a < NumWords; a++) begin
      issue_write(addr_t'(a), data_t'(rand_bits(DataWidth)), '1);
    end
    drive_idle();
    for (int unsigned a = 0; a < NumWords; a++) begin
      read_check("full_write_read", addr_t'(a));
    end
    report_test("full_write_read", e0);
  endtask

  task automatic test_byte_enables();
    int unsigned e0;
    addr_t       a;
    be_t         b;
    e0 = errors;
    for (int unsigned i = 0; i < NumByteOps; i++) begin
      a = addr_t'(rand_bits(AddrWidth));
      b = be_t'(rand_bits(BeWidth));
      if (i % 4 == 0) b[BeWidth-1] = 1'b1;  // top byte, the 7-bit field at 39
      issue_write(a, data_t'(rand_bits(DataWidth)), b);
      read_check("byte_enables", a);  // read right after the write
    end
    report_test("byte_enables", e0);
  endtask

  task automatic test_neighbor_isolation();
    int unsigned e0;
    addr_t       base;
    e0   = errors;
    base = addr_t'(rand_bits(AddrWidth)) & ~addr_t'(7);  // group sharing rows
    for (int unsigned k = 0; k < 8; k++) begin
      issue_write(base | addr_t'(k), data_t'(rand_bits(DataWidth)),
                  be_t'(rand_bits(BeWidth)));
    end
    drive_idle();
    for (int unsigned k = 0; k < 8; k++) begin
      read_check("neighbor_isolation", base | addr_t'(k));
    end
    report_test("neighbor_isolation", e0);
  endtask

  task automatic test_hold_and_pipeline();
    int unsigned e0;
    addr_t       hold_addr;
    data_t       hold_val;
    addr_t       rd_addr [4];
    data_t       exp_rd [4];
    e0        = errors;
    hold_addr = addr_t'(rand_bits(AddrWidth));
    hold_val  = model_read(hold_addr);
    read_check("hold_and_pipeline", hold_addr);
    for (int unsigned k = 0; k < 3; k++) begin
      drive_idle();
      @(negedge clk);
      check_data("hold_and_pipeline", hold_val, rdata);
    end
    // writes to other words, some in the same rows
    for (int unsigned k = 0; k < 4; k++) begin
      issue_write(hold_addr ^ addr_t'(k + 1), data_t'(rand_bits(DataWidth)), '1);
      @(negedge clk);
      check_data("hold_and_pipeline", hold_val, rdata);
    end
    drive_idle();
    @(negedge clk);
    check_data("hold_and_pipeline", hold_val, rdata);  // after the last write landed
    for (int unsigned k = 0; k < 4; k++) begin
      rd_addr[k] = addr_t'(rand_bits(AddrWidth));
      exp_rd[k]  = model_read(rd_addr[k]);
    end
    issue_read(rd_addr[0]);
    for (int unsigned k = 1; k < 4; k++) begin
      issue_read(rd_addr[k]);
      @(negedge clk);
      check_data("hold_and_pipeline", exp_rd[k-1], rdata);
    end
    drive_idle();
    @(negedge clk);
    check_data("hold_and_pipeline", exp_rd[3], rdata);
    report_test("hold_and_pipeline", e0);
  endtask

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TimeoutCycles) begin
      $display("timeout: tests did not finish within %0d cycles", TimeoutCycles);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  initial begin
    req   <= 1'b0;
    we    <= 1'b0;
    addr  <= '0;
    wdata <= '0;
    be    <= '0;
    wait (rst_n === 1'b1);
    test_reset_state();
    test_full_write_read();
    test_byte_enables();
    test_neighbor_isolation();
    test_hold_and_pipeline();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

//--- verilog.f
+incdir+verif
common/sram_pkg.sv
sram_macro/sram_macro_64.sv
rtl/sram_fold_field.sv
rtl/sram_tc.sv
verif/tb_clk_gen.sv
verif/tb_sram_tc.sv
